// File: tb/button_fifo_tests.txt
# name operation switch_word expected_word (hex)
# operations: write hold read both glitch gap; expected only matters for read and both
gap_start    gap    00 00
write_1      write  11 00
write_2      write  22 00
glitch_1     glitch ee 00
write_3      write  33 00
write_4      hold   44 00
write_5      write  55 00
write_6      write  66 00
write_7      write  77 00
write_8      write  88 00
write_over   write  99 00
swap_full    both   a1 11
read_1       read   00 22
read_2       read   00 33
read_3       hold   00 44
read_4       read   00 55
gap_mid      gap    00 00
read_5       read   00 66
read_6       read   00 77
read_7       read   00 88
read_8       read   00 a1
read_empty   read   00 a1
both_empty   both   5c 5c
read_empty2  read   00 5c
write_a      write  3c 00
write_b      write  4d 00
swap_mid     both   6e 3c
glitch_2     glitch ff 00
read_b       read   00 4d
read_c       read   00 6e
write_c      write  01 00
write_d      write  02 00
swap_two     both   03 01
swap_three   both   04 02
read_d       read   00 03
read_e       read   00 04
both_empty2  both   a5 a5
write_e      write  5a 00
read_f       read   00 5a
glitch_3     glitch 77 00
gap_end      gap    00 00
read_final   read   00 5a

// File: button_fifo.f
verilog/fifo_pkg.sv
verilog/button_debounce.sv
verilog/fifo_control.sv
verilog/fifo_storage.sv
verilog/button_fifo.sv
tb/button_fifo_sva.sv
tb/button_fifo_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = button_fifo_tb
FILELIST  = button_fifo.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL
PASS_MSG  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/button_fifo_tb.sv
`timescale 1ns/10ps

module button_fifo_tb;

  localparam int addr_bits       = 3;
  localparam int data_bits       = 8;
  localparam int debounce_cycles = 4;
  localparam int hold_cycles     = debounce_cycles + 3;   // press and release time
  localparam int depth           = 2 ** addr_bits;

  logic                 clock;
  logic                 reset;
  logic                 write_button;
  logic                 read_button;
  logic [data_bits-1:0] switches;
  logic [data_bits-1:0] dout;
  logic                 dout_valid;
  logic                 empty;
  logic                 full;
  logic                 reject;
  logic                 ready;
  logic [addr_bits:0]   occupancy;

  string                names[$];      // one entry per test line
  string                ops[$];
  logic [data_bits-1:0] words[$];      // switch word
  logic [data_bits-1:0] expects[$];    // expected read word
  logic [data_bits-1:0] model[$];      // reference FIFO contents
  logic [data_bits-1:0] last_dout;     // word dout should hold
  logic [data_bits-1:0] seen_dout;     // dout captured at dout_valid
  int                   valid_count;   // strobes seen in one operation
  int                   reject_count;
  int                   value_errors;
  int                   strobe_errors;
  int                   cycle_count;
  int                   cycle_limit;

  button_fifo #(
    .addr_bits       (addr_bits),
    .data_bits       (data_bits),
    .debounce_cycles (debounce_cycles)
  ) button_fifo_inst (
    .clock        (clock),
    .reset        (reset),
    .write_button (write_button),
    .read_button  (read_button),
    .switches     (switches),
    .dout         (dout),
    .dout_valid   (dout_valid),
    .empty        (empty),
    .full         (full),
    .reject       (reject),
    .ready        (ready),
    .occupancy    (occupancy)
  );

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;   // 10 ns period
  end

  // run limit, set properly once the test file is read
  always @(posedge clock)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("timeout after %0d cycles, DUT stopped responding", cycle_count);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // sample at the falling edge, then step to just after the next rising edge
  task automatic sample_cycle();
    @(negedge clock);
    if (dout_valid)
    begin
      valid_count = valid_count + 1;
      seen_dout   = dout;
    end
    if (reject)
      reject_count = reject_count + 1;
    @(posedge clock);
    #1;
  endtask

  task automatic push_buttons(input logic w, input logic r, input int high, input int low);
    valid_count  = 0;
    reject_count = 0;
    write_button = w;
    read_button  = r;
    repeat (high) sample_cycle();
    write_button = 1'b0;
    read_button  = 1'b0;
    repeat (low) sample_cycle();
  endtask

  task automatic check_strobes(input string name, input int valids, input int rejects);
    assert (valid_count == valids)
    else
    begin
      strobe_errors++;
      $display("%s: expected %0d dout_valid strobes but saw %0d", name, valids, valid_count);
    end
    assert (reject_count == rejects)
    else
    begin
      strobe_errors++;
      $display("%s: expected %0d reject strobes but saw %0d", name, rejects, reject_count);
    end
  endtask

  task automatic check_word(input string name, input logic [data_bits-1:0] expected,
                            input logic [data_bits-1:0] actual);
    assert (actual == expected)
    else
    begin
      value_errors++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // occupancy and flags against the queue model
  task automatic check_flags(input string name);
    assert (int'(occupancy) == model.size())
    else
    begin
      value_errors++;
      $display("ERR %s occupancy expected %0d actual %0d", name, model.size(), occupancy);
    end
    assert (empty == (model.size() == 0))
    else
    begin
      value_errors++;
      $display("ERR %s empty expected %0b actual %0b", name, model.size() == 0, empty);
    end
    assert (full == (model.size() == depth))
    else
    begin
      value_errors++;
      $display("ERR %s full expected %0b actual %0b", name, model.size() == depth, full);
    end
  endtask

  task automatic read_tests();
    int                   fd;
    int                   fields;
    string                line;
    string                name;
    string                op;
    logic [data_bits-1:0] word;
    logic [data_bits-1:0] expected;
    fd = $fopen("tb/button_fifo_tests.txt", "r");
    if (fd == 0)
      $display("cannot open tb/button_fifo_tests.txt");
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        fields = $fgets(line, fd);
        if (line.len() > 1 && line[0] != "#")
        begin
          fields = $sscanf(line, "%s %s %h %h", name, op, word, expected);
          if (fields == 4)
          begin
            names.push_back(name);
            ops.push_back(op);
            words.push_back(word);
            expects.push_back(expected);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_line(input int i);
    string                name;
    string                op;
    int                   high;
    logic [data_bits-1:0] front;
    name     = names[i];
    op       = ops[i];
    high     = hold_cycles;
    switches = words[i];
    if (op == "hold")
    begin
      high = 4 * hold_cycles;                        // long press, still one operation
      op   = (expects[i] != '0) ? "read" : "write";  // a held read names its word
    end
    case (op)
      "write":
      begin
        push_buttons(1'b1, 1'b0, high, hold_cycles);
        if (model.size() == depth)
          check_strobes(name, 0, 1);         // full, word is refused
        else
        begin
          check_strobes(name, 0, 0);
          model.push_back(words[i]);
        end
      end
      "read":
      begin
        push_buttons(1'b0, 1'b1, high, hold_cycles);
        if (model.size() == 0)
        begin
          check_strobes(name, 0, 1);
          check_word(name, last_dout, dout);   // dout holds its word
        end
        else
        begin
          front = model.pop_front();
          check_word({name, "_file"}, front, expects[i]);
          check_strobes(name, 1, 0);
          check_word(name, expects[i], seen_dout);
          last_dout = front;
        end
      end
      "both":
      begin
        push_buttons(1'b1, 1'b1, hold_cycles, hold_cycles);
        if (model.size() == 0)
          front = words[i];                  // stored first, then read back
        else
        begin
          front = model.pop_front();
          model.push_back(words[i]);
        end
        check_word({name, "_file"}, front, expects[i]);
        check_strobes(name, 1, 0);
        check_word(name, expects[i], seen_dout);
        last_dout = front;
      end
      "glitch":
      begin
        push_buttons(1'b1, 1'b1, debounce_cycles - 2, 2 * hold_cycles);
        check_strobes(name, 0, 0);
      end
      default:
      begin
        push_buttons(1'b0, 1'b0, 0, hold_cycles);   // idle gap
        check_strobes(name, 0, 0);
      end
    endcase
    check_flags(name);
  endtask

  initial
  begin
    reset         = 1'b1;
    write_button  = 1'b0;
    read_button   = 1'b0;
    switches      = '0;
    last_dout     = '0;
    seen_dout     = '0;
    valid_count   = 0;
    reject_count  = 0;
    value_errors  = 0;
    strobe_errors = 0;
    cycle_count   = 0;
    cycle_limit   = 1000;
    read_tests();
    assert (names.size() > 0)
    else
    begin
      strobe_errors++;
      $display("no test lines were read, nothing to run");
    end
    cycle_limit = names.size() * 4 * (debounce_cycles + 6) + 200;
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    push_buttons(1'b0, 1'b0, 0, hold_cycles);   // quiet after reset
    check_strobes("after_reset", 0, 0);
    assert (ready)
    else
    begin
      strobe_errors++;
      $display("after_reset: ready lamp did not light");
    end
    check_flags("after_reset");
    for (int i = 0; i < names.size(); i++)
      run_line(i);
    $display("errors: value %0d strobe %0d total %0d",
             value_errors, strobe_errors, value_errors + strobe_errors);
    if (value_errors + strobe_errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: tb/button_fifo_sva.sv
`timescale 1ns/10ps

module button_fifo_sva #(
  parameter int addr_bits = fifo_pkg::default_addr_bits
) (
  input logic                  clock,
  input logic                  reset,
  input logic                  fetch_enable,
  input logic [addr_bits:0]    occupancy,
  input logic                  empty,
  input logic                  full,
  input logic                  dout_valid
);

  localparam int depth = 2 ** addr_bits;

  // dout_valid is a single-cycle strobe
  valid_single: assert property (@(posedge clock) disable iff (reset)
    dout_valid |=> !dout_valid)
    else $error("dout_valid held for two cycles");

  flags_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(full && empty))
    else $error("full and empty high together");

  occupancy_bound: assert property (@(posedge clock) disable iff (reset)
    int'(occupancy) <= depth)
    else $error("occupancy above depth");

  // registered read word shows up one cycle after the fetch
  fetch_then_valid: assert property (@(posedge clock) disable iff (reset)
    fetch_enable |=> dout_valid)
    else $error("fetch not followed by dout_valid");

endmodule

bind fifo_control button_fifo_sva #(.addr_bits(addr_bits)) button_fifo_sva_inst (
  .clock        (clock),
  .reset        (reset),
  .fetch_enable (fetch_enable),
  .occupancy    (occupancy),
  .empty        (empty),
  .full         (full),
  .dout_valid   (dout_valid)
);

// File: verilog/button_fifo.sv
`timescale 1ns/10ps

module button_fifo #(
  parameter int addr_bits       = fifo_pkg::default_addr_bits,
  parameter int data_bits       = fifo_pkg::default_data_bits,
  parameter int debounce_cycles = fifo_pkg::default_debounce_cycles
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 write_button,   // raw push button
  input  logic                 read_button,    // raw push button
  input  logic [data_bits-1:0] switches,       // word to store
  output logic [data_bits-1:0] dout,           // last word read
  output logic                 dout_valid,
  output logic                 empty,
  output logic                 full,
  output logic                 reject,
  output logic                 ready,
  output logic [addr_bits:0]   occupancy
);

  logic                 write_press;    // one strobe per write press
  logic                 read_press;     // one strobe per read press
  logic                 store_enable;
  logic [addr_bits-1:0] store_addr;
  logic                 fetch_enable;
  logic [addr_bits-1:0] fetch_addr;

  button_debounce #(
    .debounce_cycles (debounce_cycles)
  ) write_debounce (
    .clock  (clock),
    .reset  (reset),
    .button (write_button),
    .press  (write_press)
  );

  button_debounce #(
    .debounce_cycles (debounce_cycles)
  ) read_debounce (
    .clock  (clock),
    .reset  (reset),
    .button (read_button),
    .press  (read_press)
  );

  fifo_control #(
    .addr_bits (addr_bits)
  ) fifo_control_inst (
    .clock        (clock),
    .reset        (reset),
    .write_press  (write_press),
    .read_press   (read_press),
    .store_enable (store_enable),
    .store_addr   (store_addr),
    .fetch_enable (fetch_enable),
    .fetch_addr   (fetch_addr),
    .occupancy    (occupancy),
    .empty        (empty),
    .full         (full),
    .dout_valid   (dout_valid),
    .reject       (reject),
    .ready        (ready)
  );

  fifo_storage #(
    .addr_bits (addr_bits),
    .data_bits (data_bits)
  ) fifo_storage_inst (
    .clock        (clock),
    .store_enable (store_enable),
    .store_addr   (store_addr),
    .store_data   (switches),     // sampled in the write cycle
    .fetch_enable (fetch_enable),
    .fetch_addr   (fetch_addr),
    .fetch_data   (dout)          // register drives the LEDs directly
  );

endmodule

// File: verilog/fifo_storage.sv
`timescale 1ns/10ps

module fifo_storage #(
  parameter int addr_bits = fifo_pkg::default_addr_bits,
  parameter int data_bits = fifo_pkg::default_data_bits
) (
  input  logic                 clock,
  input  logic                 store_enable,   // write strobe from the controller
  input  logic [addr_bits-1:0] store_addr,
  input  logic [data_bits-1:0] store_data,     // switch word
  input  logic                 fetch_enable,   // read strobe from the controller
  input  logic [addr_bits-1:0] fetch_addr,
  output logic [data_bits-1:0] fetch_data      // registered read word
);

  localparam int words = 2 ** addr_bits;

  logic [data_bits-1:0] word_array [words];    // 2^addr_bits entries

  // write port, word lands at the clock edge
  always_ff @(posedge clock)
  begin
    if (store_enable)
      word_array[store_addr] <= store_data;
  end

  // read port, holds its word between fetches
  always_ff @(posedge clock)
  begin
    if (fetch_enable)
      fetch_data <= word_array[fetch_addr];    // same address gives the old word
  end

  // no range checks here, the controller refuses bad requests
  // pointers wrap inside addr_bits so every address is legal
  // a swap on a full FIFO reads and writes one slot together
  // the nonblocking write makes the read see the previous contents
  // so the oldest word leaves as the new one takes its place
  // fetch_data is the dout lamp word and stays put on refused reads
  // store_data comes straight from the switches
  // the word captured is the one present in the write cycle
  // words and data_bits fix the array at elaboration
  // this maps onto distributed or block RAM with a registered output
  // both ports share one clock

endmodule

// File: verilog/fifo_control.sv
`timescale 1ns/10ps

module fifo_control #(
  parameter int addr_bits = fifo_pkg::default_addr_bits
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 write_press,   // debounced write strobe
  input  logic                 read_press,    // debounced read strobe
  output logic                 store_enable,
  output logic [addr_bits-1:0] store_addr,
  output logic                 fetch_enable,
  output logic [addr_bits-1:0] fetch_addr,
  output logic [addr_bits:0]   occupancy,     // words held
  output logic                 empty,
  output logic                 full,
  output logic                 dout_valid,    // new word on dout this cycle
  output logic                 reject,        // refused or dropped request
  output logic                 ready          // lamp, high after reset
);

  import fifo_pkg::*;

  localparam logic [addr_bits:0] depth = {1'b1, {addr_bits{1'b0}}};

  ctrl_state_t          state;
  ctrl_state_t          state_next;
  logic                 write_pending;       // write waiting for idle
  logic                 read_pending;        // read waiting for idle
  logic                 write_pending_next;
  logic                 read_pending_next;
  logic                 write_request;       // strobe or pending write
  logic                 read_request;        // strobe or pending read
  logic                 write_take;          // idle consumes the write
  logic                 read_take;           // idle consumes the read
  logic                 refuse;              // write when full or read when empty
  logic                 overflow;            // press on an occupied pending slot
  logic [addr_bits-1:0] write_ptr;           // next slot to store, wraps
  logic [addr_bits-1:0] read_ptr;            // oldest word, wraps
  logic [addr_bits:0]   occupancy_next;

  assign write_request = write_pending | write_press;
  assign read_request  = read_pending | read_press;

  always_comb
  begin
    state_next = state;
    write_take = 1'b0;
    read_take  = 1'b0;
    refuse     = 1'b0;
    case (state)
      ctrl_idle:
      begin
        if (write_request && read_request)
        begin
          write_take = 1'b1;
          if (empty)
            state_next = ctrl_write;   // store first, read stays pending
          else
          begin
            read_take  = 1'b1;
            state_next = ctrl_swap;    // works when full as well
          end
        end
        else if (write_request)
        begin
          write_take = 1'b1;
          if (full)
            refuse = 1'b1;
          else
            state_next = ctrl_write;
        end
        else if (read_request)
        begin
          read_take = 1'b1;
          if (empty)
            refuse = 1'b1;             // dout keeps its old word
          else
            state_next = ctrl_read;
        end
      end
      ctrl_read, ctrl_swap: state_next = ctrl_show;   // storage word lands next cycle
      default:              state_next = ctrl_idle;   // write and show last one cycle
    endcase
  end

  // a taken slot keeps a press arriving in the same cycle
  assign write_pending_next = write_take ? (write_pending & write_press)
                                         : (write_pending | write_press);
  assign read_pending_next  = read_take ? (read_pending & read_press)
                                        : (read_pending | read_press);
  assign overflow = (!write_take && write_press && write_pending)
                 || (!read_take && read_press && read_pending);

  always_comb
  begin
    case (state)
      ctrl_write: occupancy_next = occupancy + 1'b1;
      ctrl_read:  occupancy_next = occupancy - 1'b1;
      default:    occupancy_next = occupancy;   // swap leaves the count alone
    endcase
  end

  assign store_enable = (state == ctrl_write) || (state == ctrl_swap);
  assign store_addr   = write_ptr;
  assign fetch_enable = (state == ctrl_read) || (state == ctrl_swap);
  assign fetch_addr   = read_ptr;
  assign dout_valid   = (state == ctrl_show);

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state         <= ctrl_idle;
      write_pending <= 1'b0;
      read_pending  <= 1'b0;
      write_ptr     <= '0;
      read_ptr      <= '0;
      occupancy     <= '0;
      empty         <= 1'b1;
      full          <= 1'b0;
      reject        <= 1'b0;
      ready         <= 1'b0;
    end
    else
    begin
      state         <= state_next;
      write_pending <= write_pending_next;
      read_pending  <= read_pending_next;
      if (store_enable)
        write_ptr <= write_ptr + 1'b1;   // natural wrap at depth
      if (fetch_enable)
        read_ptr <= read_ptr + 1'b1;
      occupancy <= occupancy_next;
      empty     <= (occupancy_next == '0);
      full      <= (occupancy_next == depth);
      reject    <= refuse | overflow;    // one cycle after the idle decision
      ready     <= 1'b1;
    end
  end

endmodule

// File: verilog/button_debounce.sv
`timescale 1ns/10ps

module button_debounce #(
  parameter int debounce_cycles = fifo_pkg::default_debounce_cycles
) (
  input  logic clock,
  input  logic reset,
  input  logic button,   // raw level from the push button
  output logic press     // one-cycle strobe per accepted press
);

  // counter only has to reach debounce_cycles - 1
  localparam int count_bits = (debounce_cycles > 1) ? $clog2(debounce_cycles) : 1;
  localparam logic [count_bits-1:0] count_limit = count_bits'(debounce_cycles - 1);

  logic                  sync_first;   // first synchronizer stage
  logic                  sync_second;  // second stage, safe to use
  logic                  level;        // debounced button level
  logic [count_bits-1:0] stable_count; // cycles the new level has held
  logic                  changed;      // synchronized input differs from level
  logic                  flip;         // new level held long enough

  assign changed = (sync_second != level);
  assign flip    = changed && (stable_count == count_limit);

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      sync_first  <= 1'b0;
      sync_second <= 1'b0;
    end
    else
    begin
      sync_first  <= button;       // metastability guard
      sync_second <= sync_first;
    end
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      stable_count <= '0;
      level        <= 1'b0;
      press        <= 1'b0;
    end
    else
    begin
      press <= flip && sync_second;             // rising flip only
      if (!changed)
        stable_count <= '0;                     // bounce back, start over
      else if (flip)
      begin
        level        <= sync_second;            // accept the new level
        stable_count <= '0;
      end
      else
        stable_count <= stable_count + 1'b1;    // still counting
    end
  end

  // latency raw edge to press is two sync stages plus debounce_cycles
  // a pulse shorter than debounce_cycles never reaches the limit
  // release is debounced the same way but emits no strobe

endmodule

// File: verilog/fifo_pkg.sv
package fifo_pkg;

  // controller states, one-hot is not needed for five states
  typedef enum logic [2:0] {
    ctrl_idle  = 3'd0,   // waiting for a strobe or a pending request
    ctrl_write = 3'd1,   // store one word, one cycle
    ctrl_read  = 3'd2,   // fetch the oldest word
    ctrl_swap  = 3'd3,   // fetch oldest and store new in one cycle
    ctrl_show  = 3'd4    // fetched word visible on dout
  } ctrl_state_t;

  // address width, 3 bits gives 8 words
  parameter int default_addr_bits = 3;

  // switch word width
  parameter int default_data_bits = 8;

  // cycles the synchronized button must stay stable
  parameter int default_debounce_cycles = 16;

  // depth of the FIFO in words follows from the address width
  // occupancy needs one bit more than the address to hold the full count
  // empty is occupancy zero, full is occupancy equal to the depth

  // a press is one strobe no matter how long the button is held
  // strobes that arrive while busy wait in a single pending slot
  // a second press on an occupied slot is dropped and rejected

  // raw press to dout_valid is debounce_cycles + 4 in the quiet case

endpackage
